// ==== list.f ====
+incdir+include
rtl/gmm_pkg.sv
rtl/gmm_csr.sv
rtl/stream_stage.sv
rtl/mem_header_strip.sv
rtl/gmm_classifier.sv
rtl/gmm_packet_ctrl.sv
rtl/gmm_out_framer.sv
rtl/gmm_fg_top.sv
verification/tb_clock.sv
verification/gmm_fg_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the foreground detector testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
	--top-module gmm_fg_tb -o gmm_fg_sim
if [ $? -ne 0 ]; then
	echo "verilator compile step returned an error"
	exit 1
fi

out=$(./obj_dir/gmm_fg_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q "Simulation passed"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== verification/gmm_fg_tb.sv ====
// directed testbench for the foreground detector shell
// register map, control forwarding, seeded and stored frames, back-pressure
`include "gmm_defs.svh"

module gmm_fg_tb;

	localparam int timeout_cycles = 2000;
	localparam int npix = 4;              // 2x2 frame
	localparam logic [7:0] test_thr = 8'd20;

	logic clk, rst;
	logic cpu_cs, cpu_write, cpu_read;
	logic [3:0] cpu_addr;
	logic [31:0] cpu_writedata, cpu_readdata;
	logic in_video_valid, in_video_sop, in_video_eop, in_video_ready;
	logic [23:0] in_video_data;
	logic in_mem_valid, in_mem_sop, in_mem_eop, in_mem_ready;
	logic [127:0] in_mem_data;
	logic out_video_ready = 1'b1;
	logic out_mem_ready = 1'b1;
	logic out_video_valid, out_video_sop, out_video_eop;
	logic [48:0] out_video_data;
	logic out_mem_valid, out_mem_sop, out_mem_eop;
	logic [127:0] out_mem_data;

	logic [50:0] vid_got[$], vid_exp[$];    // {sop, eop, data}
	logic [129:0] mem_got[$], mem_exp[$];
	gmm_pkg::rgb888_t pix_tab[npix];
	gmm_pkg::mem_rec_t rec_tab[npix];
	logic [255:0] vid_rdy_pat, mem_rdy_pat;
	logic bp_en = 1'b0;
	logic mem_closed = 1'b1;                 // memory input must stay shut
	int bp_cyc = 0;

	tb_clock #(.period(40)) clock_gen (.clk(clk));

	gmm_fg_top dut (.*);

	task automatic check(input string name, input logic [129:0] got, input logic [129:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout at %0t while waiting for %s", $time, what);
		$display("Simulation failed");
		$fatal(1);
	endtask

	// output monitors, sampled mid-cycle
	always @(negedge clk) begin
		if (!rst && out_video_valid && out_video_ready) begin
			vid_got.push_back({out_video_sop, out_video_eop, out_video_data});
		end
		if (!rst && out_mem_valid && out_mem_ready) begin
			mem_got.push_back({out_mem_sop, out_mem_eop, out_mem_data});
		end
		if (mem_closed) begin
			check("in_mem_ready", in_mem_ready, 1'b0);
		end
	end

	always @(posedge clk) begin
		if (bp_en) begin
			out_video_ready <= vid_rdy_pat[bp_cyc[7:0]];
			out_mem_ready <= mem_rdy_pat[bp_cyc[7:0]];
			bp_cyc <= bp_cyc + 1;
		end else begin
			out_video_ready <= 1'b1;
			out_mem_ready <= 1'b1;
		end
	end

	function automatic logic [127:0] size_model(input logic [15:0] w, input logic [15:0] h);
		logic [127:0] v;
		logic [35:0] nib;
		v = '0;
		nib = {`GMM_IL_NIBBLE, h[3:0], h[7:4], h[11:8], h[15:12],
			w[3:0], w[7:4], w[11:8], w[15:12]};
		for (int k = 0; k < 9; k++) begin
			v[8*k +: 4] = nib[4*k +: 4];   // even nibbles only
		end
		return v;
	endfunction

	function automatic gmm_pkg::mem_rec_t seed_model(input gmm_pkg::rgb888_t p);
		gmm_pkg::mem_rec_t r;
		r.clusters_num = 2'd1;
		r.chm = '0;
		r.u = '0;
		for (int k = 0; k < 3; k++) begin
			r.cluster[k].rgb_std = `GMM_SEED_STD;
			r.cluster[k].w = `GMM_SEED_W;
			r.cluster[k].rgb_mean = p;
		end
		return r;
	endfunction

	function automatic logic fg_model(input gmm_pkg::rgb888_t p, input gmm_pkg::rgb888_t m);
		int diff;
		logic fg;
		fg = 1'b0;
		for (int c = 0; c < 3; c++) begin
			diff = int'(p[8*c +: 8]) - int'(m[8*c +: 8]);
			if (diff < 0) begin
				diff = -diff;
			end
			if (diff > int'(test_thr)) begin
				fg = 1'b1;
			end
		end
		return fg;
	endfunction

	task automatic write_csr(input logic [3:0] addr, input logic [31:0] data);
		@(posedge clk);
		cpu_cs <= 1'b1;
		cpu_write <= 1'b1;
		cpu_addr <= addr;
		cpu_writedata <= data;
		@(posedge clk);
		cpu_cs <= 1'b0;
		cpu_write <= 1'b0;
	endtask

	task automatic read_csr_check(input logic [3:0] addr, input logic [31:0] exp);
		@(posedge clk);
		cpu_cs <= 1'b1;
		cpu_read <= 1'b1;
		cpu_addr <= addr;
		@(negedge clk);
		check("cpu_readdata", cpu_readdata, exp);
		@(posedge clk);
		cpu_cs <= 1'b0;
		cpu_read <= 1'b0;
	endtask

	task automatic send_video(input logic sop, input logic eop, input logic [23:0] data);
		int n;
		@(posedge clk);
		in_video_valid <= 1'b1;
		in_video_sop <= sop;
		in_video_eop <= eop;
		in_video_data <= data;
		n = 0;
		@(negedge clk);
		while (!in_video_ready) begin
			n++;
			if (n > timeout_cycles) begin
				report_timeout("in_video_ready");
			end
			@(negedge clk);
		end
	endtask

	task automatic send_mem(input logic sop, input logic eop, input logic [127:0] data);
		int n;
		@(posedge clk);
		in_mem_valid <= 1'b1;
		in_mem_sop <= sop;
		in_mem_eop <= eop;
		in_mem_data <= data;
		n = 0;
		@(negedge clk);
		while (!in_mem_ready) begin
			n++;
			if (n > timeout_cycles) begin
				report_timeout("in_mem_ready");
			end
			@(negedge clk);
		end
	endtask

	task automatic video_idle();
		@(posedge clk);   // last beat moves on this edge
		in_video_valid <= 1'b0;
		in_video_sop <= 1'b0;
		in_video_eop <= 1'b0;
	endtask

	task automatic mem_idle();
		@(posedge clk);
		in_mem_valid <= 1'b0;
		in_mem_sop <= 1'b0;
		in_mem_eop <= 1'b0;
	endtask

	// control beats come back unchanged in new_pixel
	task automatic fwd_beat(input logic sop, input logic eop, input logic [23:0] data);
		vid_exp.push_back({sop, eop, 25'd0, data});
		send_video(sop, eop, data);
	endtask

	task automatic send_ctrl_packet(input logic [15:0] w, input logic [15:0] h);
		fwd_beat(1'b1, 1'b0, {20'd0, `GMM_TYPE_CTRL});
		fwd_beat(1'b0, 1'b0, {4'h0, w[7:4], 4'h0, w[11:8], 4'h0, w[15:12]});
		fwd_beat(1'b0, 1'b0, {4'h0, h[11:8], 4'h0, h[15:12], 4'h0, w[3:0]});
		fwd_beat(1'b0, 1'b1, {12'd0, h[3:0], 4'h0, h[7:4]});
		video_idle();
	endtask

	task automatic send_drop_packet();
		send_video(1'b1, 1'b0, 24'h000005);   // unknown type nibble
		send_video(1'b0, 1'b0, 24'($urandom));
		send_video(1'b0, 1'b1, 24'($urandom));
		video_idle();
	endtask

	task automatic send_frame();
		send_video(1'b1, 1'b0, {20'd0, `GMM_TYPE_VIDEO});
		for (int i = 0; i < npix; i++) begin
			send_video(1'b0, i == npix - 1, pix_tab[i]);
		end
		video_idle();
	endtask

	task automatic send_mem_stream();
		send_mem(1'b1, 1'b0, {124'd0, `GMM_TYPE_CTRL});
		send_mem(1'b0, 1'b1, size_model(16'd2, 16'd2));
		send_mem(1'b1, 1'b0, {124'd0, `GMM_TYPE_VIDEO});
		for (int i = 0; i < npix; i++) begin
			send_mem(1'b0, i == npix - 1, rec_tab[i]);
		end
		mem_idle();
	endtask

	task automatic expect_frame(input logic seeded);
		gmm_pkg::mem_rec_t r;
		gmm_pkg::rgb888_t m;
		mem_exp.push_back({2'b10, 124'd0, `GMM_TYPE_CTRL});
		mem_exp.push_back({2'b01, size_model(16'd2, 16'd2)});
		mem_exp.push_back({2'b10, 128'd0});
		vid_exp.push_back({2'b10, 49'd0});
		for (int i = 0; i < npix; i++) begin
			r = (seeded || rec_tab[i].clusters_num == 2'd0) ? seed_model(pix_tab[i]) : rec_tab[i];
			m = r.cluster[0].rgb_mean;
			vid_exp.push_back({1'b0, i == npix - 1, fg_model(pix_tab[i], m), m, pix_tab[i]});
			mem_exp.push_back({1'b0, i == npix - 1, r});
		end
	endtask

	task automatic wait_and_compare();
		int n;
		logic [50:0] gv;
		logic [129:0] gm;
		n = 0;
		while (vid_got.size() < vid_exp.size() || mem_got.size() < mem_exp.size()) begin
			@(negedge clk);
			n++;
			if (n > timeout_cycles) begin
				report_timeout("output beats");
			end
		end
		repeat (20) @(negedge clk);   // any extra beat shows up here
		check("out_video beat count", vid_got.size(), vid_exp.size());
		check("out_mem beat count", mem_got.size(), mem_exp.size());
		foreach (vid_exp[i]) begin
			gv = vid_got[i];
			check($sformatf("out_video_sop[%0d]", i), gv[50], vid_exp[i][50]);
			check($sformatf("out_video_eop[%0d]", i), gv[49], vid_exp[i][49]);
			check($sformatf("out_video_data[%0d]", i), gv[48:0], vid_exp[i][48:0]);
		end
		foreach (mem_exp[i]) begin
			gm = mem_got[i];
			check($sformatf("out_mem_sop[%0d]", i), gm[129], mem_exp[i][129]);
			check($sformatf("out_mem_eop[%0d]", i), gm[128], mem_exp[i][128]);
			check($sformatf("out_mem_data[%0d]", i), gm[127:0], mem_exp[i][127:0]);
		end
		vid_got.delete();
		vid_exp.delete();
		mem_got.delete();
		mem_exp.delete();
	endtask

	task automatic make_tables();
		for (int i = 0; i < npix; i++) begin
			pix_tab[i].r = 8'(32 + $urandom % 192);   // keeps offsets below from wrapping
			pix_tab[i].g = 8'(32 + $urandom % 192);
			pix_tab[i].b = 8'(32 + $urandom % 192);
			rec_tab[i] = {$urandom, $urandom, $urandom, $urandom};
			rec_tab[i].clusters_num = 2'(1 + $urandom % 3);
		end
		rec_tab[0].cluster[0].rgb_mean = pix_tab[0];
		rec_tab[0].cluster[0].rgb_mean.g = pix_tab[0].g - 8'd6;    // background
		rec_tab[1].cluster[0].rgb_mean = pix_tab[1];
		rec_tab[1].cluster[0].rgb_mean.b = pix_tab[1].b + 8'd30;   // foreground
		rec_tab[2].clusters_num = 2'd0;                              // empty record
		for (int k = 0; k < 8; k++) begin
			vid_rdy_pat[32*k +: 32] = $urandom;
			mem_rdy_pat[32*k +: 32] = $urandom;
		end
	endtask

	task automatic test_csr();
		read_csr_check(4'd0, 32'd9);
		write_csr(4'd0, {24'd0, test_thr});
		read_csr_check(4'd0, {24'd0, test_thr});
		read_csr_check(4'd5, 32'd0);
	endtask

	task automatic test_stored_frame();
		expect_frame(1'b0);
		fork
			send_frame();
			send_mem_stream();
		join
		wait_and_compare();
	endtask

	initial begin
		void'($urandom(32'h4075));
		rst = 1'b1;
		cpu_cs = 1'b0;
		cpu_write = 1'b0;
		cpu_read = 1'b0;
		cpu_addr = '0;
		cpu_writedata = '0;
		in_video_valid = 1'b0;
		in_video_sop = 1'b0;
		in_video_eop = 1'b0;
		in_video_data = '0;
		in_mem_valid = 1'b0;
		in_mem_sop = 1'b0;
		in_mem_eop = 1'b0;
		in_mem_data = '0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		make_tables();
		test_csr();
		send_ctrl_packet(16'd2, 16'd2);   // 2x2 size, forwarded only
		wait_and_compare();
		expect_frame(1'b1);               // first frame seeds every record
		send_frame();
		mem_closed = 1'b0;
		wait_and_compare();
		test_stored_frame();
		bp_en = 1'b1;
		test_stored_frame();
		bp_en = 1'b0;
		send_drop_packet();
		send_ctrl_packet(16'd2, 16'd2);
		wait_and_compare();
		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== verification/tb_clock.sv ====
// free-running testbench clock
module tb_clock #(
	parameter int period = 40
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#(period / 2) clk = ~clk;   // half period per phase
		end
	end

endmodule

// ==== rtl/gmm_fg_top.sv ====
// foreground detector stream shell
// register map, input stages, classifier, control and output framer
`include "gmm_defs.svh"

module gmm_fg_top (
	input logic clk,
	input logic rst,
	input logic cpu_cs,
	input logic cpu_write,
	input logic cpu_read,
	input logic [`GMM_CSR_ADDR_W-1:0] cpu_addr,
	input logic [31:0] cpu_writedata,
	output logic [31:0] cpu_readdata,
	input logic in_video_valid,
	input logic in_video_sop,
	input logic in_video_eop,
	input logic [23:0] in_video_data,
	output logic in_video_ready,
	input logic in_mem_valid,
	input logic in_mem_sop,
	input logic in_mem_eop,
	input logic [`GMM_MEM_W-1:0] in_mem_data,
	output logic in_mem_ready,
	input logic out_video_ready,
	output logic out_video_valid,
	output logic out_video_sop,
	output logic out_video_eop,
	output logic [48:0] out_video_data,
	input logic out_mem_ready,
	output logic out_mem_valid,
	output logic out_mem_sop,
	output logic out_mem_eop,
	output logic [`GMM_MEM_W-1:0] out_mem_data
);

	gmm_pkg::rgb888_t vs_data;
	gmm_pkg::mem_rec_t rec, cls_rec;
	gmm_pkg::out_pix_t cls_beat;
	gmm_pkg::beat_kind_t beat_kind;
	logic [`GMM_SIZE_W-1:0] width, height;
	logic [7:0] thr_d;
	logic vs_valid, vs_sop, vs_eop, vs_ready;
	logic pix_valid, pix_last, pix_ready, seed;
	logic rec_valid, rec_ready, strip_en;
	logic cls_valid, cls_last, cls_ready;
	logic beat_valid, beat_sop, beat_eop, beat_ready, frame_done;

	gmm_csr csr (.clk, .rst, .cpu_cs, .cpu_write, .cpu_read, .cpu_addr, .cpu_writedata,
		.cpu_readdata, .thr_d);

	stream_stage #(
		.payload_t(gmm_pkg::rgb888_t)
	) vid_stage (
		.clk, .rst,
		.in_valid(in_video_valid), .in_sop(in_video_sop), .in_eop(in_video_eop),
		.in_data(gmm_pkg::rgb888_t'(in_video_data)), .in_ready(in_video_ready),
		.out_valid(vs_valid), .out_sop(vs_sop), .out_eop(vs_eop),
		.out_data(vs_data), .out_ready(vs_ready)
	);

	mem_header_strip strip (.clk, .rst, .en(strip_en), .in_mem_valid, .in_mem_sop,
		.in_mem_eop, .in_mem_data, .in_mem_ready, .rec_valid, .rec, .rec_ready);

	gmm_classifier classifier (.clk, .rst, .pix_valid, .pix(vs_data), .pix_last, .seed,
		.pix_ready, .rec_valid, .rec, .rec_ready, .thr_d, .cls_valid, .cls_beat, .cls_rec,
		.cls_last, .cls_ready);

	gmm_packet_ctrl ctrl (.clk, .rst, .vid_valid(vs_valid), .vid_sop(vs_sop),
		.vid_eop(vs_eop), .vid_data(vs_data), .vid_ready(vs_ready), .pix_valid, .pix_last,
		.seed, .pix_ready, .beat_valid, .beat_kind, .beat_sop, .beat_eop, .beat_ready,
		.width, .height, .strip_en, .frame_done);

	gmm_out_framer framer (.clk, .rst, .beat_valid, .beat_kind, .beat_sop, .beat_eop,
		.vid_data(vs_data), .width, .height, .beat_ready, .cls_valid, .cls_beat, .cls_rec,
		.cls_last, .cls_ready, .frame_done, .out_video_ready, .out_video_valid,
		.out_video_sop, .out_video_eop, .out_video_data, .out_mem_ready, .out_mem_valid,
		.out_mem_sop, .out_mem_eop, .out_mem_data);

endmodule

// ==== rtl/gmm_out_framer.sv ====
// output registers for the video and memory streams
// header, size, forwarded and pixel beat formats
`include "gmm_defs.svh"

module gmm_out_framer (
	input logic clk,
	input logic rst,
	input logic beat_valid,
	input gmm_pkg::beat_kind_t beat_kind,
	input logic beat_sop,
	input logic beat_eop,
	input gmm_pkg::rgb888_t vid_data,
	input logic [`GMM_SIZE_W-1:0] width,
	input logic [`GMM_SIZE_W-1:0] height,
	output logic beat_ready,
	input logic cls_valid,
	input gmm_pkg::out_pix_t cls_beat,
	input gmm_pkg::mem_rec_t cls_rec,
	input logic cls_last,
	output logic cls_ready,
	output logic frame_done,
	input logic out_video_ready,
	output logic out_video_valid,
	output logic out_video_sop,
	output logic out_video_eop,
	output logic [$bits(gmm_pkg::out_pix_t)-1:0] out_video_data,
	input logic out_mem_ready,
	output logic out_mem_valid,
	output logic out_mem_sop,
	output logic out_mem_eop,
	output logic [`GMM_MEM_W-1:0] out_mem_data
);

	gmm_pkg::beat_kind_t ld_kind;
	gmm_pkg::out_pix_t vid_nxt;
	logic [`GMM_MEM_W-1:0] mem_nxt, size_beat;
	logic vid_free, mem_free, ld, wr_vid, wr_mem;
	logic vid_sop_nxt, vid_eop_nxt, mem_sop_nxt, mem_eop_nxt;

	function automatic logic writes_vid(input gmm_pkg::beat_kind_t kind);
		return (kind != gmm_pkg::MEM_HDR) && (kind != gmm_pkg::MEM_SIZE);
	endfunction

	function automatic logic writes_mem(input gmm_pkg::beat_kind_t kind);
		return kind != gmm_pkg::CTRL_FWD;
	endfunction

	function automatic logic kind_fits(input gmm_pkg::beat_kind_t kind, input logic vf,
		input logic mf);
		return (!writes_vid(kind) || vf) && (!writes_mem(kind) || mf);
	endfunction

	assign vid_free = ~out_video_valid | out_video_ready;
	assign mem_free = ~out_mem_valid | out_mem_ready;
	assign cls_ready = kind_fits(gmm_pkg::PIXEL, vid_free, mem_free);
	assign beat_ready = ~cls_valid & kind_fits(beat_kind, vid_free, mem_free);   // pixels first
	assign ld_kind = cls_valid ? gmm_pkg::PIXEL : beat_kind;
	assign ld = (cls_valid & cls_ready) | (beat_valid & beat_ready);
	assign wr_vid = ld & writes_vid(ld_kind);
	assign wr_mem = ld & writes_mem(ld_kind);
	assign frame_done = cls_valid & cls_ready & cls_last;

	// descriptor nibble layout, width first
	assign size_beat = {{(`GMM_MEM_W - 72){1'b0}}, 4'd0, `GMM_IL_NIBBLE,
		4'd0, height[3:0], 4'd0, height[7:4], 4'd0, height[11:8], 4'd0, height[15:12],
		4'd0, width[3:0], 4'd0, width[7:4], 4'd0, width[11:8], 4'd0, width[15:12]};

	always_comb begin
		vid_nxt = '0;
		mem_nxt = '0;
		vid_sop_nxt = 1'b0;
		vid_eop_nxt = 1'b0;
		mem_sop_nxt = 1'b0;
		mem_eop_nxt = 1'b0;
		case (ld_kind)
			gmm_pkg::MEM_HDR: begin
				mem_nxt = {{(`GMM_MEM_W - 4){1'b0}}, `GMM_TYPE_CTRL};
				mem_sop_nxt = 1'b1;
			end
			gmm_pkg::MEM_SIZE: begin
				mem_nxt = size_beat;
				mem_eop_nxt = 1'b1;
			end
			gmm_pkg::VID_HDR: begin
				vid_sop_nxt = 1'b1;
				mem_sop_nxt = 1'b1;
			end
			gmm_pkg::CTRL_FWD: begin
				vid_nxt.new_pixel = vid_data;
				vid_sop_nxt = beat_sop;
				vid_eop_nxt = beat_eop;
			end
			default: begin
				vid_nxt = cls_beat;
				mem_nxt = cls_rec;
				vid_eop_nxt = cls_last;
				mem_eop_nxt = cls_last;
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			out_video_valid <= 1'b0;
			out_mem_valid <= 1'b0;
		end else begin
			if (wr_vid) begin
				out_video_valid <= 1'b1;
			end else if (out_video_ready) begin
				out_video_valid <= 1'b0;
			end
			if (wr_mem) begin
				out_mem_valid <= 1'b1;
			end else if (out_mem_ready) begin
				out_mem_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_vid) begin
			out_video_sop <= vid_sop_nxt;
			out_video_eop <= vid_eop_nxt;
			out_video_data <= vid_nxt;
		end
		if (wr_mem) begin
			out_mem_sop <= mem_sop_nxt;
			out_mem_eop <= mem_eop_nxt;
			out_mem_data <= mem_nxt;
		end
	end

endmodule

// ==== rtl/gmm_packet_ctrl.sv ====
// reader and writer sequencing for the video stream
// descriptor decode, pixel count, first-frame flag
`include "gmm_defs.svh"

module gmm_packet_ctrl (
	input logic clk,
	input logic rst,
	input logic vid_valid,
	input logic vid_sop,
	input logic vid_eop,
	input gmm_pkg::rgb888_t vid_data,
	output logic vid_ready,
	output logic pix_valid,
	output logic pix_last,
	output logic seed,
	input logic pix_ready,
	output logic beat_valid,
	output gmm_pkg::beat_kind_t beat_kind,
	output logic beat_sop,
	output logic beat_eop,
	input logic beat_ready,
	output logic [`GMM_SIZE_W-1:0] width,
	output logic [`GMM_SIZE_W-1:0] height,
	output logic strip_en,
	input logic frame_done
);

	gmm_pkg::pkt_t pkt_q, cur_pkt;
	gmm_pkg::beat_kind_t hdr_kind;
	logic [23:0] vid_raw;
	logic [2:0] desc_cnt;
	logic [2*`GMM_SIZE_W-1:0] frame_px, pix_cnt;
	logic first_frame;
	logic vid_take, pix_take, hdr_take;

	assign vid_raw = vid_data;
	assign frame_px = width * height;

	// a sop beat names its own packet
	always_comb begin
		cur_pkt = pkt_q;
		if (vid_sop) begin
			if (vid_raw[3:0] == `GMM_TYPE_CTRL) begin
				cur_pkt = gmm_pkg::CONTROL;
			end else if (vid_raw[3:0] == `GMM_TYPE_VIDEO) begin
				cur_pkt = gmm_pkg::VIDEO;
			end else begin
				cur_pkt = gmm_pkg::DROP;
			end
		end
	end

	always_comb begin
		vid_ready = 1'b1;   // dropped beats are simply taken
		pix_valid = 1'b0;
		beat_valid = 1'b0;
		beat_kind = gmm_pkg::CTRL_FWD;
		case (cur_pkt)
			gmm_pkg::CONTROL: begin
				beat_valid = vid_valid;
				vid_ready = beat_ready;
			end
			gmm_pkg::VIDEO: begin
				if (vid_sop) begin
					beat_valid = vid_valid;
					beat_kind = hdr_kind;
					vid_ready = beat_ready && (hdr_kind == gmm_pkg::VID_HDR);
				end else begin
					pix_valid = vid_valid;
					vid_ready = pix_ready;
				end
			end
			default: ;
		endcase
	end

	assign beat_sop = vid_sop;
	assign beat_eop = vid_eop;
	assign vid_take = vid_valid & vid_ready;
	assign pix_take = pix_valid & pix_ready;
	assign hdr_take = beat_valid & beat_ready & (cur_pkt == gmm_pkg::VIDEO);
	assign pix_last = (pix_cnt == frame_px - 1'b1);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pkt_q <= gmm_pkg::IDLE;
			hdr_kind <= gmm_pkg::MEM_HDR;
			pix_cnt <= '0;
		end else begin
			if (vid_take) begin
				pkt_q <= vid_eop ? gmm_pkg::IDLE : cur_pkt;
			end
			if (hdr_take) begin
				case (hdr_kind)
					gmm_pkg::MEM_HDR: hdr_kind <= gmm_pkg::MEM_SIZE;
					gmm_pkg::MEM_SIZE: hdr_kind <= gmm_pkg::VID_HDR;
					default: hdr_kind <= gmm_pkg::MEM_HDR;
				endcase
			end
			if (hdr_take && hdr_kind == gmm_pkg::VID_HDR) begin
				pix_cnt <= '0;
			end else if (pix_take) begin
				pix_cnt <= pix_cnt + 1'b1;
			end
		end
	end

	// size descriptor, three nibbles per beat
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			desc_cnt <= '0;
			width <= '0;
			height <= '0;
		end else if (vid_take && cur_pkt == gmm_pkg::CONTROL) begin
			if (vid_sop) begin
				desc_cnt <= 3'd1;
			end else begin
				if (desc_cnt < 3'd4) begin
					desc_cnt <= desc_cnt + 3'd1;
				end
				case (desc_cnt)
					3'd1: width[15:4] <= {vid_raw[3:0], vid_raw[11:8], vid_raw[19:16]};
					3'd2: begin
						width[3:0] <= vid_raw[3:0];
						height[15:8] <= {vid_raw[11:8], vid_raw[19:16]};
					end
					3'd3: height[7:0] <= {vid_raw[3:0], vid_raw[11:8]};
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			first_frame <= 1'b1;
		end else if (frame_done) begin
			first_frame <= 1'b0;
		end
	end

	assign seed = first_frame;
	assign strip_en = ~first_frame;

	a_pix_bound: assert property (@(posedge clk) disable iff (rst) pix_cnt <= frame_px);

endmodule

// ==== rtl/gmm_classifier.sv ====
// pixel and record join with seeding
// foreground decision against cluster 0, registered result
`include "gmm_defs.svh"

module gmm_classifier (
	input logic clk,
	input logic rst,
	input logic pix_valid,
	input gmm_pkg::rgb888_t pix,
	input logic pix_last,
	input logic seed,
	output logic pix_ready,
	input logic rec_valid,
	input gmm_pkg::mem_rec_t rec,
	output logic rec_ready,
	input logic [7:0] thr_d,
	output logic cls_valid,
	output gmm_pkg::out_pix_t cls_beat,
	output gmm_pkg::mem_rec_t cls_rec,
	output logic cls_last,
	input logic cls_ready
);

	gmm_pkg::mem_rec_t seed_rec, use_rec;
	gmm_pkg::rgb888_t mean0;
	logic slot_free, take, fg;

	function automatic logic [7:0] abs_diff(input logic [7:0] a, input logic [7:0] b);
		return (a > b) ? a - b : b - a;
	endfunction

	assign slot_free = ~cls_valid | cls_ready;
	assign pix_ready = (seed | rec_valid) & slot_free;
	assign rec_ready = ~seed & pix_valid & slot_free;   // both taken together
	assign take = pix_valid & pix_ready;

	always_comb begin
		seed_rec.clusters_num = 2'd1;
		seed_rec.chm = '0;
		seed_rec.u = '0;
		for (int i = 0; i < 3; i++) begin
			seed_rec.cluster[i].rgb_std = `GMM_SEED_STD;
			seed_rec.cluster[i].w = `GMM_SEED_W;
			seed_rec.cluster[i].rgb_mean = pix;
		end
	end

	assign use_rec = (seed || rec.clusters_num == 2'd0) ? seed_rec : rec;
	assign mean0 = use_rec.cluster[0].rgb_mean;
	assign fg = (abs_diff(pix.r, mean0.r) > thr_d) || (abs_diff(pix.g, mean0.g) > thr_d)
		|| (abs_diff(pix.b, mean0.b) > thr_d);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cls_valid <= 1'b0;
		end else if (take) begin
			cls_valid <= 1'b1;
		end else if (cls_ready) begin
			cls_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			cls_beat.is_fg <= fg;
			cls_beat.mem_pixel <= mean0;
			cls_beat.new_pixel <= pix;
			cls_rec <= use_rec;
			cls_last <= pix_last;
		end
	end

	// records arrive only once the seeding frame is over
	a_rec_join: assert property (@(posedge clk) disable iff (rst)
		seed |-> !rec_valid);

endmodule

// ==== rtl/mem_header_strip.sv ====
// memory record input
// drops control packets and the video header, forwards records
`include "gmm_defs.svh"

module mem_header_strip (
	input logic clk,
	input logic rst,
	input logic en,
	input logic in_mem_valid,
	input logic in_mem_sop,
	input logic in_mem_eop,
	input logic [`GMM_MEM_W-1:0] in_mem_data,
	output logic in_mem_ready,
	output logic rec_valid,
	output gmm_pkg::mem_rec_t rec,
	input logic rec_ready
);

	gmm_pkg::mem_rec_t stg_data;
	logic [`GMM_MEM_W-1:0] stg_raw;
	logic stg_in_ready;
	logic stg_valid, stg_sop, stg_eop;
	logic stg_ready, stg_take;
	logic in_rec;   // inside the record packet

	stream_stage #(
		.payload_t(gmm_pkg::mem_rec_t)
	) rec_stage (
		.clk(clk),
		.rst(rst),
		.in_valid(en & in_mem_valid),
		.in_sop(in_mem_sop),
		.in_eop(in_mem_eop),
		.in_data(gmm_pkg::mem_rec_t'(in_mem_data)),
		.in_ready(stg_in_ready),
		.out_valid(stg_valid),
		.out_sop(stg_sop),
		.out_eop(stg_eop),
		.out_data(stg_data),
		.out_ready(stg_ready)
	);

	assign in_mem_ready = en & stg_in_ready;
	assign stg_raw = stg_data;
	assign rec = stg_data;
	assign rec_valid = in_rec & stg_valid;
	assign stg_ready = in_rec ? rec_ready : 1'b1;   // discard outside records
	assign stg_take = stg_valid & stg_ready;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			in_rec <= 1'b0;
		end else if (stg_take) begin
			if (!in_rec) begin
				in_rec <= stg_sop && !stg_eop && (stg_raw[3:0] == `GMM_TYPE_VIDEO);
			end else if (stg_eop) begin
				in_rec <= 1'b0;
			end
		end
	end

endmodule

// ==== rtl/stream_stage.sv ====
// single-beat registered stream stage with sop/eop
// payload type chosen per instance
module stream_stage #(
	parameter type payload_t = logic [7:0]
) (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic in_sop,
	input logic in_eop,
	input payload_t in_data,
	output logic in_ready,
	output logic out_valid,
	output logic out_sop,
	output logic out_eop,
	output payload_t out_data,
	input logic out_ready
);

	assign in_ready = out_ready | ~out_valid;   // refill while draining

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			out_sop <= in_sop;
			out_eop <= in_eop;
			out_data <= in_data;
		end
	end

	// upstream keeps a stalled beat unchanged
	a_hold_stable: assert property (@(posedge clk) disable iff (rst)
		in_valid && !in_ready |=> in_valid && $stable(in_data)
			&& $stable(in_sop) && $stable(in_eop));

endmodule

// ==== rtl/gmm_csr.sv ====
// CPU register map
// holds the foreground threshold d
`include "gmm_defs.svh"

module gmm_csr (
	input logic clk,
	input logic rst,
	input logic cpu_cs,
	input logic cpu_write,
	input logic cpu_read,
	input logic [`GMM_CSR_ADDR_W-1:0] cpu_addr,
	input logic [31:0] cpu_writedata,
	output logic [31:0] cpu_readdata,
	output logic [7:0] thr_d
);

	logic sel_d;

	assign sel_d = cpu_cs && (cpu_addr == `GMM_CSR_D_ADDR);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			thr_d <= `GMM_D_RESET;
		end else if (cpu_write && sel_d) begin
			thr_d <= cpu_writedata[7:0];
		end
	end

	always_comb begin
		if (cpu_read && sel_d) begin
			cpu_readdata = {24'd0, thr_d};
		end else begin
			cpu_readdata = '0;   // unmapped or idle
		end
	end

endmodule

// ==== rtl/gmm_pkg.sv ====
// shared types for the foreground detector
// pixel, cluster and record formats, packet and beat encodings
package gmm_pkg;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb888_t;

	typedef struct packed {
		logic [5:0] rgb_std;   // colour deviation
		logic [7:0] w;         // distribution weight
		rgb888_t rgb_mean;
	} cluster_t;

	// one memory beat per pixel
	typedef struct packed {
		logic [1:0] clusters_num;
		logic [5:0] chm;       // times seen as foreground
		logic [5:0] u;
		cluster_t [2:0] cluster;
	} mem_rec_t;

	typedef struct packed {
		logic is_fg;
		rgb888_t mem_pixel;    // cluster 0 mean
		rgb888_t new_pixel;    // camera pixel
	} out_pix_t;

	typedef enum logic [1:0] {
		IDLE, CONTROL, VIDEO, DROP
	} pkt_t;

	typedef enum logic [2:0] {
		MEM_HDR, MEM_SIZE, VID_HDR, PIXEL, CTRL_FWD
	} beat_kind_t;

endpackage

// ==== include/gmm_defs.svh ====
// width, register map and encoding macros for the foreground detector
`ifndef GMM_DEFS_SVH
`define GMM_DEFS_SVH

`define GMM_CSR_ADDR_W 4
`define GMM_CSR_D_ADDR 4'd0   // threshold register
`define GMM_D_RESET 8'd9

`define GMM_SIZE_W 16         // width and height counters

`define GMM_TYPE_CTRL 4'hF
`define GMM_TYPE_VIDEO 4'h0

`define GMM_MEM_W 128         // one record per memory beat

`define GMM_SEED_W 8'd3       // weight of a freshly seeded cluster
`define GMM_SEED_STD 6'd17

`define GMM_IL_NIBBLE 4'h2    // interlace field of the size beat

`endif
